//--- logic/uart_pkg.sv
// UART controller package with shared widths, register map, status bits and FSM states
`default_nettype none

package uart_pkg;

    typedef logic [7:0]  byte_t;      // One serial data byte
    typedef logic [31:0] word_t;      // One bus data word
    typedef logic [3:0]  reg_addr_t;  // Register byte address
    typedef logic [15:0] baud_div_t;  // Clock cycles per serial bit

    localparam int FIFO_AW    = 5;    // Index bits of a FIFO slot
    localparam int FIFO_DEPTH = 32;

    typedef logic [FIFO_AW:0] fifo_ptr_t;  // Extra MSB is the wrap bit

    localparam reg_addr_t ADDR_CTRL   = 4'h0;
    localparam reg_addr_t ADDR_STATUS = 4'h4;
    localparam reg_addr_t ADDR_RXDATA = 4'h8;
    localparam reg_addr_t ADDR_TXDATA = 4'hC;

    localparam int STAT_TX_FULL  = 0;
    localparam int STAT_RX_FULL  = 1;
    localparam int STAT_TX_EMPTY = 2;
    localparam int STAT_RX_EMPTY = 3;

    localparam int CTRL_TX_EN   = 0;
    localparam int CTRL_RX_EN   = 1;
    localparam int CTRL_DIV_LSB = 16;  // Divisor occupies bits 31..16

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

`default_nettype wire

//--- logic/uart_fifo.sv
// Byte FIFO of FIFO_DEPTH entries with show-ahead head and full/empty flags
`timescale 1ns/1ps
`default_nettype none

module uart_fifo
    import uart_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  push_i,
    input  byte_t push_data_i,
    input  logic  pop_i,
    output byte_t head_o,
    output logic  full_o,
    output logic  empty_o
);

    byte_t     mem_q [FIFO_DEPTH];
    fifo_ptr_t wr_ptr_q;
    fifo_ptr_t rd_ptr_q;
    logic      push_ok;

    // Same slot, wrap bits differ when the FIFO is full
    assign full_o  = (wr_ptr_q[FIFO_AW] != rd_ptr_q[FIFO_AW]) &&
                     (wr_ptr_q[FIFO_AW-1:0] == rd_ptr_q[FIFO_AW-1:0]);
    assign empty_o = (wr_ptr_q == rd_ptr_q);

    assign push_ok = push_i && !full_o;  // Push while full is lost

    assign head_o = mem_q[rd_ptr_q[FIFO_AW-1:0]];  // Oldest byte

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q[FIFO_AW-1:0]] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + fifo_ptr_t'(1);
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + fifo_ptr_t'(1);  // Caller guards against empty
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_regs.sv
// UART register block decoding bus strobes into control, status and FIFO accesses
`timescale 1ns/1ps
`default_nettype none

module uart_regs
    import uart_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      bus_valid_i,
    input  logic      bus_write_i,
    input  reg_addr_t bus_addr_i,
    input  word_t     bus_wdata_i,
    output word_t     rd_data_o,
    output logic      rd_valid_o,
    input  logic      tx_full_i,
    input  logic      tx_empty_i,
    input  logic      rx_full_i,
    input  logic      rx_empty_i,
    input  byte_t     rx_head_i,
    output logic      rx_pop_o,
    output logic      tx_push_o,
    output byte_t     tx_push_data_o,
    output logic      tx_en_o,
    output logic      rx_en_o,
    output baud_div_t baud_div_o
);

    logic  wr_access;
    logic  rd_access;
    logic  ctrl_wr;
    logic  ctrl_rd;
    logic  status_rd;
    logic  answer;
    word_t ctrl_word;
    word_t status_word;
    word_t rd_next;

    assign wr_access = bus_valid_i && bus_write_i;
    assign rd_access = bus_valid_i && !bus_write_i;

    assign ctrl_wr   = wr_access && (bus_addr_i == ADDR_CTRL);
    assign ctrl_rd   = rd_access && (bus_addr_i == ADDR_CTRL);
    assign status_rd = rd_access && (bus_addr_i == ADDR_STATUS);

    // Empty receive FIFO means no pop and no answer
    assign rx_pop_o = rd_access && (bus_addr_i == ADDR_RXDATA) && !rx_empty_i;

    assign tx_push_o      = wr_access && (bus_addr_i == ADDR_TXDATA);  // FIFO drops it when full
    assign tx_push_data_o = bus_wdata_i[7:0];

    assign answer = ctrl_rd || status_rd || rx_pop_o;

    always_comb begin
        ctrl_word = '0;
        ctrl_word[CTRL_TX_EN] = tx_en_o;
        ctrl_word[CTRL_RX_EN] = rx_en_o;
        ctrl_word[CTRL_DIV_LSB +: $bits(baud_div_t)] = baud_div_o;
    end

    always_comb begin
        status_word = '0;
        status_word[STAT_TX_FULL]  = tx_full_i;
        status_word[STAT_RX_FULL]  = rx_full_i;
        status_word[STAT_TX_EMPTY] = tx_empty_i;
        status_word[STAT_RX_EMPTY] = rx_empty_i;
    end

    always_comb begin
        if (ctrl_rd) begin
            rd_next = ctrl_word;
        end else if (status_rd) begin
            rd_next = status_word;
        end else begin
            rd_next = {24'd0, rx_head_i};  // Head byte popped in this cycle
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_en_o    <= 1'b0;
            rx_en_o    <= 1'b0;
            baud_div_o <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= answer;  // One-cycle answer strobe
            if (ctrl_wr) begin
                tx_en_o    <= bus_wdata_i[CTRL_TX_EN];
                rx_en_o    <= bus_wdata_i[CTRL_RX_EN];
                baud_div_o <= bus_wdata_i[CTRL_DIV_LSB +: $bits(baud_div_t)];
            end
        end
    end

    // Read data held until the next answer
    always_ff @(posedge clk_i) begin
        if (answer) begin
            rd_data_o <= rd_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
// UART transmit engine serializing 8N1 frames from the transmit FIFO
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      tx_en_i,
    input  baud_div_t baud_div_i,
    input  logic      fifo_empty_i,
    input  byte_t     data_i,
    output logic      pop_o,
    output logic      tx_o,
    output logic      busy_o
);

    tx_state_t state_q;
    baud_div_t baud_cnt_q;
    logic [2:0] bit_cnt_q;
    byte_t     shift_q;
    logic      bit_end;
    logic      take;

    assign bit_end = (baud_cnt_q == baud_div_i - baud_div_t'(1));

    // New frame from idle, or straight after a stop bit
    assign take = tx_en_i && !fifo_empty_i &&
                  ((state_q == TX_IDLE) || ((state_q == TX_STOP) && bit_end));

    assign pop_o  = take;
    assign busy_o = (state_q != TX_IDLE) || !fifo_empty_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= TX_IDLE;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            tx_o       <= 1'b1;  // Idle line is high
        end else if (take) begin
            state_q    <= TX_START;
            baud_cnt_q <= '0;
            tx_o       <= 1'b0;  // Start bit
        end else if (state_q != TX_IDLE) begin
            baud_cnt_q <= bit_end ? '0 : baud_cnt_q + baud_div_t'(1);
            if (bit_end) begin
                case (state_q)
                    TX_START: begin
                        state_q   <= TX_DATA;
                        bit_cnt_q <= '0;
                        tx_o      <= shift_q[0];  // LSB first
                    end
                    TX_DATA: begin
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= TX_STOP;
                            tx_o    <= 1'b1;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                            tx_o      <= shift_q[0];
                        end
                    end
                    default: state_q <= TX_IDLE;  // End of stop bit
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            shift_q <= data_i;
        end else if (bit_end && ((state_q == TX_START) || (state_q == TX_DATA))) begin
            shift_q <= shift_q >> 1;  // Next bit moves to bit 0
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
// UART receive engine sampling 8N1 frames mid-bit and flagging each good byte
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      rx_en_i,
    input  baud_div_t baud_div_i,
    input  logic      rx_i,
    output logic      valid_o,
    output byte_t     data_o
);

    logic       rx_meta_q;
    logic       rx_sync_q;
    logic       rx_prev_q;
    logic       fall;
    rx_state_t  state_q;
    baud_div_t  baud_cnt_q;
    baud_div_t  half_div;
    logic [2:0] bit_cnt_q;
    byte_t      shift_q;
    logic       half_end;
    logic       bit_end;

    assign half_div = baud_div_i >> 1;
    assign half_end = (baud_cnt_q == half_div - baud_div_t'(1));
    assign bit_end  = (baud_cnt_q == baud_div_i - baud_div_t'(1));
    assign fall     = rx_prev_q && !rx_sync_q;

    assign data_o = shift_q;  // Stable until the next frame's first data bit

    // Two-flop synchronizer plus edge history, idling high
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || !rx_en_i) begin
            state_q    <= RX_IDLE;  // Disable drops any frame in progress
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            valid_o    <= 1'b0;
        end else begin
            valid_o    <= 1'b0;
            baud_cnt_q <= baud_cnt_q + baud_div_t'(1);
            case (state_q)
                RX_IDLE: begin
                    baud_cnt_q <= '0;
                    if (fall) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_end) begin
                        baud_cnt_q <= '0;
                        bit_cnt_q  <= '0;
                        // False start if the line went back high
                        state_q    <= rx_sync_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt_q <= '0;
                        bit_cnt_q  <= bit_cnt_q + 3'd1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        valid_o <= rx_sync_q;  // Low stop bit discards the byte
                        state_q <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == RX_DATA) && bit_end) begin
            shift_q <= {rx_sync_q, shift_q[7:1]};  // LSB arrives first
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_controller.sv
// Memory-mapped UART controller joining registers, FIFOs and serial engines
`timescale 1ns/1ps
`default_nettype none

module uart_controller
    import uart_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      bus_valid_i,
    input  logic      bus_write_i,
    input  reg_addr_t bus_addr_i,
    input  word_t     bus_wdata_i,
    output word_t     rd_data_o,
    output logic      rd_valid_o,
    input  logic      uart_rx_i,
    output logic      uart_tx_o,
    output logic      busy_o
);

    logic      tx_push;
    byte_t     tx_push_data;
    logic      tx_pop;
    byte_t     tx_head;
    logic      tx_full;
    logic      tx_empty;
    logic      rx_push;
    byte_t     rx_push_data;
    logic      rx_pop;
    byte_t     rx_head;
    logic      rx_full;
    logic      rx_empty;
    logic      tx_en;
    logic      rx_en;
    baud_div_t baud_div;

    uart_regs i_uart_regs (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .bus_valid_i    (bus_valid_i),
        .bus_write_i    (bus_write_i),
        .bus_addr_i     (bus_addr_i),
        .bus_wdata_i    (bus_wdata_i),
        .rd_data_o      (rd_data_o),
        .rd_valid_o     (rd_valid_o),
        .tx_full_i      (tx_full),
        .tx_empty_i     (tx_empty),
        .rx_full_i      (rx_full),
        .rx_empty_i     (rx_empty),
        .rx_head_i      (rx_head),
        .rx_pop_o       (rx_pop),
        .tx_push_o      (tx_push),
        .tx_push_data_o (tx_push_data),
        .tx_en_o        (tx_en),
        .rx_en_o        (rx_en),
        .baud_div_o     (baud_div)
    );

    uart_fifo i_tx_fifo (  // Bus to serial line
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (tx_push),
        .push_data_i (tx_push_data),
        .pop_i       (tx_pop),
        .head_o      (tx_head),
        .full_o      (tx_full),
        .empty_o     (tx_empty)
    );

    uart_fifo i_rx_fifo (  // Serial line to bus
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (rx_push),
        .push_data_i (rx_push_data),
        .pop_i       (rx_pop),
        .head_o      (rx_head),
        .full_o      (rx_full),
        .empty_o     (rx_empty)
    );

    uart_tx i_uart_tx (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .tx_en_i      (tx_en),
        .baud_div_i   (baud_div),
        .fifo_empty_i (tx_empty),
        .data_i       (tx_head),
        .pop_o        (tx_pop),
        .tx_o         (uart_tx_o),
        .busy_o       (busy_o)
    );

    uart_rx i_uart_rx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rx_en_i    (rx_en),
        .baud_div_i (baud_div),
        .rx_i       (uart_rx_i),
        .valid_o    (rx_push),
        .data_o     (rx_push_data)
    );

endmodule

`default_nettype wire

//--- testbench/uart_controller_tb.sv
// Testbench for the UART controller with bus tasks, a serial line model and random traffic
`timescale 1ns/1ps
`default_nettype none

module uart_controller_tb
    import uart_pkg::*;
();

    localparam int BAUD      = 8;     // Divisor used for all serial traffic
    localparam int READ_WAIT = 20;    // Cycles allowed for a read answer
    localparam int EDGE_WAIT = 3000;  // Cycles allowed for a frame start or idle
    localparam int POLL_MAX  = 100;   // STATUS reads allowed for a received byte

    logic      clk;
    logic      rst;
    logic      bus_valid;
    logic      bus_write;
    reg_addr_t bus_addr;
    word_t     bus_wdata;
    word_t     rd_data;
    logic      rd_valid;
    logic      uart_rx;
    logic      uart_tx;
    logic      busy;

    int    seed = 88;
    int    pass_cnt = 0;
    int    fail_cnt = 0;
    byte_t tx_model[$];  // Bytes expected on the serial output
    byte_t rx_model[$];  // Bytes expected from RXDATA

    uart_controller i_uart_controller (
        .clk_i       (clk),
        .rst_i       (rst),
        .bus_valid_i (bus_valid),
        .bus_write_i (bus_write),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .rd_data_o   (rd_data),
        .rd_valid_o  (rd_valid),
        .uart_rx_i   (uart_rx),
        .uart_tx_o   (uart_tx),
        .busy_o      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic note_fail(input string msg);
        $display("Error at %0t: %s", $time, msg);
        fail_cnt++;
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    function automatic word_t status_exp(input logic txf, input logic rxf,
                                         input logic txe, input logic rxe);
        word_t w;
        w = '0;
        w[STAT_TX_FULL]  = txf;
        w[STAT_RX_FULL]  = rxf;
        w[STAT_TX_EMPTY] = txe;
        w[STAT_RX_EMPTY] = rxe;
        return w;
    endfunction

    task automatic bus_write_word(input reg_addr_t addr, input word_t data);
        @(posedge clk);
        bus_valid <= 1'b1;
        bus_write <= 1'b1;
        bus_addr  <= addr;
        bus_wdata <= data;
        @(posedge clk);
        bus_valid <= 1'b0;
    endtask

    // Answer is sampled on falling edges, away from the DUT's updates
    task automatic bus_read(input reg_addr_t addr, input logic want, output word_t data);
        int   n;
        logic got;
        @(posedge clk);
        bus_valid <= 1'b1;
        bus_write <= 1'b0;
        bus_addr  <= addr;
        @(posedge clk);
        bus_valid <= 1'b0;
        n = 0;
        got = 1'b0;
        while (!got && n < READ_WAIT) begin
            @(negedge clk);
            got = rd_valid;
            n++;
        end
        data = got ? rd_data : '0;
        if (!got && want) begin
            note_fail("read got no answer");
        end else if (got && !want) begin
            note_fail("read of an empty RXDATA got an answer");
        end else if (!want) begin
            pass_cnt++;  // Silence was expected
        end
    endtask

    task automatic drive_bit(input logic b);
        @(posedge clk);
        uart_rx <= b;
        repeat (BAUD - 1) @(posedge clk);
    endtask

    task automatic send_frame(input byte_t data, input logic stop_bit);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);  // LSB first
        end
        drive_bit(stop_bit);
        if (!stop_bit) begin
            drive_bit(1'b1);  // Back to idle line
        end
    endtask

    task automatic expect_frame();
        int    n;
        logic  seen;
        byte_t data;
        logic  stop;
        n = 0;
        seen = 1'b0;
        while (!seen && n < EDGE_WAIT) begin
            @(negedge clk);
            seen = (uart_tx == 1'b0);
            n++;
        end
        if (!seen) begin
            note_fail("no frame start seen on the serial output");
        end else begin
            repeat (BAUD / 2) @(negedge clk);  // Middle of the start bit
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD) @(negedge clk);
                data[i] = uart_tx;
            end
            repeat (BAUD) @(negedge clk);
            stop = uart_tx;
            if (tx_model.size() == 0) begin
                note_fail("frame sent that was never written");
            end else begin
                check_word({23'd0, stop, data}, {23'd0, 1'b1, tx_model.pop_front()},
                           "serial frame");
            end
        end
    endtask

    // Line must stay high, a start bit here is a frame nobody wrote
    task automatic expect_no_frame(input int cycles);
        int   n;
        logic low;
        n = 0;
        low = 1'b0;
        while (!low && n < cycles) begin
            @(negedge clk);
            low = (uart_tx == 1'b0);
            n++;
        end
        check_flag(low, 1'b0, "serial output started an extra frame");
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < EDGE_WAIT * 40) begin
            @(negedge clk);
            n++;
        end
        check_flag(busy, 1'b0, "busy after last frame");
    endtask

    task automatic wait_rx_byte();
        int    n;
        word_t st;
        n = 0;
        st = status_exp(1'b0, 1'b0, 1'b0, 1'b1);
        while (st[STAT_RX_EMPTY] && n < POLL_MAX) begin
            bus_read(ADDR_STATUS, 1'b1, st);
            n++;
        end
        if (st[STAT_RX_EMPTY]) begin
            note_fail("received byte never reached the receive FIFO");
        end
    endtask

    task automatic end_test(input string name, input int fails_before);
        $display("test %s: %0d errors", name, fail_cnt - fails_before);
    endtask

    initial begin
        word_t w;
        word_t ctrl_w;
        byte_t b;
        int    f0;
        rst       = 1'b1;
        bus_valid = 1'b0;
        bus_write = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        uart_rx   = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        f0 = fail_cnt;
        bus_read(ADDR_STATUS, 1'b1, w);
        check_word(w, status_exp(1'b0, 1'b0, 1'b1, 1'b1), "STATUS after reset");
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(uart_tx, 1'b1, "serial output after reset");
        w = $random(seed) & 32'hFFFF_0003;  // Divisor and both enable bits
        bus_write_word(ADDR_CTRL, w);
        bus_read(ADDR_CTRL, 1'b1, ctrl_w);
        check_word(ctrl_w, w, "CTRL readback");
        bus_write_word(ADDR_CTRL, 32'h0008_0003);
        end_test("reset and control", f0);

        f0 = fail_cnt;
        fork
            begin
                for (int i = 0; i < 20; i++) begin
                    b = byte_t'($random(seed));
                    tx_model.push_back(b);
                    bus_write_word(ADDR_TXDATA, {24'd0, b});
                end
            end
            begin
                for (int i = 0; i < 20; i++) begin
                    expect_frame();
                end
            end
        join
        wait_idle();
        bus_read(ADDR_STATUS, 1'b1, w);
        check_word(w, status_exp(1'b0, 1'b0, 1'b1, 1'b1), "STATUS after transmit");
        end_test("transmit", f0);

        f0 = fail_cnt;
        bus_write_word(ADDR_CTRL, 32'h0008_0002);
        for (int i = 0; i < 34; i++) begin
            b = byte_t'($random(seed));
            if (tx_model.size() < FIFO_DEPTH) begin
                tx_model.push_back(b);  // Writes beyond the depth are refused
            end
            bus_write_word(ADDR_TXDATA, {24'd0, b});
        end
        bus_read(ADDR_STATUS, 1'b1, w);
        check_word(w, status_exp(1'b1, 1'b0, 1'b0, 1'b1), "STATUS with full TX FIFO");
        bus_write_word(ADDR_CTRL, 32'h0008_0003);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            expect_frame();
        end
        expect_no_frame(12 * BAUD);
        wait_idle();
        end_test("transmit full", f0);

        f0 = fail_cnt;
        for (int i = 0; i < 10; i++) begin
            b = byte_t'($random(seed));
            send_frame(b, 1'b1);
            wait_rx_byte();
            bus_read(ADDR_RXDATA, 1'b1, w);
            check_byte(w[7:0], b, "received byte");
        end
        send_frame(byte_t'($random(seed)), 1'b0);
        repeat (4) begin
            bus_read(ADDR_STATUS, 1'b1, w);
            check_word(w, status_exp(1'b0, 1'b0, 1'b1, 1'b1), "STATUS after bad stop bit");
        end
        end_test("receive", f0);

        f0 = fail_cnt;
        for (int i = 0; i < 34; i++) begin
            b = byte_t'($random(seed));
            if (rx_model.size() < FIFO_DEPTH) begin
                rx_model.push_back(b);  // Later bytes are lost to a full FIFO
            end
            send_frame(b, 1'b1);
        end
        bus_read(ADDR_STATUS, 1'b1, w);
        check_word(w, status_exp(1'b0, 1'b1, 1'b1, 1'b0), "STATUS with full RX FIFO");
        while (rx_model.size() > 0) begin
            bus_read(ADDR_RXDATA, 1'b1, w);
            check_byte(w[7:0], rx_model.pop_front(), "buffered byte");
        end
        bus_read(ADDR_RXDATA, 1'b0, w);
        end_test("receive overflow", f0);

        f0 = fail_cnt;
        bus_write_word(ADDR_CTRL, 32'h0008_0001);
        send_frame(byte_t'($random(seed)), 1'b1);
        repeat (4) begin
            bus_read(ADDR_STATUS, 1'b1, w);
            check_word(w, status_exp(1'b0, 1'b0, 1'b1, 1'b1), "STATUS with receive off");
        end
        end_test("receive disabled", f0);

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_regs.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_controller.sv
testbench/uart_controller_tb.sv
